/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    // Primary opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // Funct codes under opRType
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnJalr = 6'h09;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    localparam logic [31:0] resetPc = 32'h0000_0000;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    // Low 26 bits double as the J-type target
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrT;

    typedef enum logic [1:0] {Rt, Rd, Ra} regDstT;
    typedef enum logic [1:0] {Alu, Mem, Link} wbSelT;
    typedef enum logic [2:0] {Add, Sub, And, Or, Slt, Lui} aluOpT;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;
        logic   branchEq;
        logic   branchNe;
        logic   jump;
        logic   jumpReg;
        regDstT regDst;
        wbSelT  wbSel;
        aluOpT  aluOp;
    } ctrlT;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        write;
    } memReqT;

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axiMstT;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiSlvT;

endpackage

`default_nettype wire

/* design/controlUnit.sv */
`default_nettype none

module controlUnit
    import mipsPkg::*;
(
    input  instrT instr,
    output ctrlT  ctrl
);

    always_comb
    begin
        // Everything off, so unknown encodings act as NOP
        ctrl.regWrite  = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.branchEq  = 1'b0;
        ctrl.branchNe  = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.jumpReg   = 1'b0;
        ctrl.regDst    = Rt;
        ctrl.wbSel     = Alu;
        ctrl.aluOp     = Add;

        case (instr.r.op)
            opRType:
            begin
                ctrl.regDst = Rd;
                case (instr.r.funct)
                    fnAddu:
                    begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = Add;
                    end
                    fnSubu:
                    begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = Sub;
                    end
                    fnAnd:
                    begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = And;
                    end
                    fnOr:
                    begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = Or;
                    end
                    fnSlt:
                    begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = Slt;
                    end
                    fnJr:
                        ctrl.jumpReg = 1'b1;
                    fnJalr:
                    begin
                        // Link goes to rd, not $ra
                        ctrl.jumpReg  = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.wbSel    = Link;
                    end
                    default:
                        ctrl.regDst = Rt;
                endcase
            end
            opAddiu:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLui:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = Lui;
            end
            opLw:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSel     = Mem;
            end
            opSw:
            begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq:
            begin
                ctrl.branchEq = 1'b1;
                ctrl.aluOp    = Sub;
            end
            opBne:
            begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = Sub;
            end
            opJ:
                ctrl.jump = 1'b1;
            opJal:
            begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = Ra;
                ctrl.wbSel    = Link;
            end
            default:
                ctrl.regDst = Rt;
        endcase
    end

endmodule

`default_nettype wire

/* design/regFile.sv */
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    input  logic        we,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);

    logic [31:0] regs [32];

    // Register 0 is cleared by reset and never written
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            regs <= '{default: '0};
        else if (we && (wrAddr != 5'd0))
            regs[wrAddr] <= wrData;
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

/* design/coreSequencer.sv */
`default_nettype none

module coreSequencer
    import mipsPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  ctrlT        ctrl,
    input  logic [31:0] rdDataA,
    input  logic [31:0] rdDataB,
    input  logic        fetchReqReady,
    input  logic        fetchRspValid,
    input  logic [31:0] fetchRspData,
    input  logic        dataReqReady,
    input  logic        dataRspValid,
    input  logic [31:0] dataRspData,
    output instrT       instr,
    output logic [4:0]  rdAddrA,
    output logic [4:0]  rdAddrB,
    output logic        we,
    output logic [4:0]  wrAddr,
    output logic [31:0] wrData,
    output logic        fetchReqValid,
    output memReqT      fetchReq,
    output logic        dataReqValid,
    output memReqT      dataReq
);

    typedef enum logic [1:0] {Fetch, Execute, Wait} seqStateT;

    seqStateT    state;
    logic [31:0] pc;
    instrT       instrReg;
    memReqT      dataReqQ;
    logic        fetchBusy;
    logic        dataBusy;
    logic [4:0]  loadDst;

    logic [31:0] signExt;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    logic        zero;
    logic        takeBranch;
    logic [4:0]  dstAddr;
    logic        fetchLeft;
    logic        dataLeft;

    assign instr   = instrReg;
    assign rdAddrA = instrReg.r.rs;
    assign rdAddrB = instrReg.r.rt;
    assign signExt = {{16{instrReg.i.imm[15]}}, instrReg.i.imm};
    assign aluB    = ctrl.aluSrcImm ? signExt : rdDataB;

    always_comb
    begin
        case (ctrl.aluOp)
            Sub:     aluResult = rdDataA - aluB;
            And:     aluResult = rdDataA & aluB;
            Or:      aluResult = rdDataA | aluB;
            Slt:     aluResult = {31'd0, $signed(rdDataA) < $signed(aluB)};
            Lui:     aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = rdDataA + aluB;
        endcase
    end

    // Branch compare reuses the subtract result
    assign zero         = (aluResult == 32'd0);
    assign takeBranch   = (ctrl.branchEq && zero) || (ctrl.branchNe && !zero);
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signExt[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instrReg.i[25:0], 2'b00};

    always_comb
    begin
        if (ctrl.jumpReg)
            nextPc = rdDataA;
        else if (ctrl.jump)
            nextPc = jumpTarget;
        else if (takeBranch)
            nextPc = branchTarget;
        else
            nextPc = pcPlus4;
    end

    always_comb
    begin
        case (ctrl.regDst)
            Rd:      dstAddr = instrReg.r.rd;
            Ra:      dstAddr = 5'd31;
            default: dstAddr = instrReg.r.rt;
        endcase
    end

    // ALU and link results land in Execute, load data on its response
    always_comb
    begin
        we     = 1'b0;
        wrAddr = dstAddr;
        wrData = (ctrl.wbSel == Link) ? pcPlus4 : aluResult;
        if (state == Execute)
            we = ctrl.regWrite && (ctrl.wbSel != Mem);
        else if ((state == Wait) && dataBusy && !dataReqQ.write && dataRspValid)
        begin
            we     = 1'b1;
            wrAddr = loadDst;
            wrData = dataRspData;
        end
    end

    assign fetchReq  = '{addr: pc, wdata: 32'd0, write: 1'b0};
    assign dataReq   = dataReqQ;
    assign fetchLeft = fetchBusy && !fetchRspValid;
    assign dataLeft  = dataBusy && !dataRspValid;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state         <= Fetch;
            pc            <= resetPc;
            fetchReqValid <= 1'b1;
            fetchBusy     <= 1'b1;
            dataReqValid  <= 1'b0;
            dataBusy      <= 1'b0;
        end
        else
        begin
            if (fetchReqReady)
                fetchReqValid <= 1'b0;
            if (dataReqReady)
                dataReqValid <= 1'b0;
            if (fetchRspValid)
                fetchBusy <= 1'b0;
            if (dataRspValid)
                dataBusy <= 1'b0;

            case (state)
                Fetch:
                    if (fetchRspValid)
                        state <= Execute;
                Execute:
                begin
                    pc            <= nextPc;
                    fetchReqValid <= 1'b1;
                    fetchBusy     <= 1'b1;
                    if (ctrl.memRead || ctrl.memWrite)
                    begin
                        dataReqValid <= 1'b1;
                        dataBusy     <= 1'b1;
                        state        <= Wait;
                    end
                    else
                        state <= Fetch;
                end
                Wait:
                    if (!fetchLeft && !dataLeft)
                        state <= Execute;
                default:
                    state <= Fetch;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetchRspValid)
            instrReg <= fetchRspData;
        if (state == Execute)
        begin
            dataReqQ <= '{addr: aluResult, wdata: rdDataB, write: ctrl.memWrite};
            loadDst  <= dstAddr;
        end
    end

endmodule

`default_nettype wire

/* design/memArbiter.sv */
`default_nettype none

module memArbiter
    import mipsPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        fetchReqValid,
    input  memReqT      fetchReq,
    input  logic        dataReqValid,
    input  memReqT      dataReq,
    input  axiSlvT      axiIn,
    output logic        fetchReqReady,
    output logic        fetchRspValid,
    output logic [31:0] fetchRspData,
    output logic        dataReqReady,
    output logic        dataRspValid,
    output logic [31:0] dataRspData,
    output axiMstT      axiOut
);

    typedef enum logic [1:0] {Idle, Addr, Resp} arbStateT;

    arbStateT    state;
    memReqT      grantReq;
    memReqT      reqQ;
    logic        ownerData;
    logic        arvalid;
    logic        awvalid;
    logic        wvalid;
    logic        rready;
    logic        bready;
    logic        rspPulse;
    logic [31:0] rspData;
    logic        awLeft;
    logic        wLeft;

    // Data port has priority
    assign dataReqReady  = (state == Idle) && dataReqValid;
    assign fetchReqReady = (state == Idle) && !dataReqValid && fetchReqValid;
    assign grantReq      = dataReqValid ? dataReq : fetchReq;

    assign awLeft = awvalid && !axiIn.awready;
    assign wLeft  = wvalid && !axiIn.wready;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state     <= Idle;
            ownerData <= 1'b0;
            arvalid   <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            rready    <= 1'b0;
            bready    <= 1'b0;
            rspPulse  <= 1'b0;
        end
        else
        begin
            rspPulse <= 1'b0;
            case (state)
                Idle:
                    if (dataReqReady || fetchReqReady)
                    begin
                        ownerData <= dataReqReady;
                        arvalid   <= !grantReq.write;
                        awvalid   <= grantReq.write;
                        wvalid    <= grantReq.write;
                        state     <= Addr;
                    end
                Addr:
                    if (reqQ.write)
                    begin
                        // aw and w may be taken in either order
                        awvalid <= awLeft;
                        wvalid  <= wLeft;
                        if (!awLeft && !wLeft)
                        begin
                            bready <= 1'b1;
                            state  <= Resp;
                        end
                    end
                    else if (axiIn.arready)
                    begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= Resp;
                    end
                Resp:
                    if ((rready && axiIn.rvalid) || (bready && axiIn.bvalid))
                    begin
                        rready   <= 1'b0;
                        bready   <= 1'b0;
                        rspPulse <= 1'b1;
                        state    <= Idle;
                    end
                default:
                    state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == Idle)
            reqQ <= grantReq;
        if (rready && axiIn.rvalid)
            rspData <= axiIn.rdata;
    end

    // Response goes back to the recorded owner only
    assign fetchRspValid = rspPulse && !ownerData;
    assign dataRspValid  = rspPulse && ownerData;
    assign fetchRspData  = rspData;
    assign dataRspData   = rspData;

    always_comb
    begin
        axiOut.awvalid = awvalid;
        axiOut.awaddr  = reqQ.addr;
        axiOut.wvalid  = wvalid;
        axiOut.wdata   = reqQ.wdata;
        axiOut.wstrb   = 4'hf;
        axiOut.bready  = bready;
        axiOut.arvalid = arvalid;
        axiOut.araddr  = reqQ.addr;
        axiOut.rready  = rready;
    end

endmodule

`default_nettype wire

/* design/mipsTop.sv */
`default_nettype none

module mipsTop
    import mipsPkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  axiSlvT axiIn,
    output axiMstT axiOut
);

    instrT       instr;
    ctrlT        ctrl;
    logic [4:0]  rdAddrA;
    logic [4:0]  rdAddrB;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic        we;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;

    // Sequencer to arbiter request ports
    logic        fetchReqValid;
    memReqT      fetchReq;
    logic        fetchReqReady;
    logic        fetchRspValid;
    logic [31:0] fetchRspData;
    logic        dataReqValid;
    memReqT      dataReq;
    logic        dataReqReady;
    logic        dataRspValid;
    logic [31:0] dataRspData;

    coreSequencer uCoreSequencer (.*);

    controlUnit uControlUnit (.*);

    regFile uRegFile (.*);

    memArbiter uMemArbiter (.*);

endmodule

`default_nettype wire

/* tests/axiMemSlave.sv */
`default_nettype none

module axiMemSlave
    import mipsPkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  axiMstT axiOut,
    output axiSlvT axiIn
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [2048];
    logic [31:0] readLog [$];
    memReqT      writeLog [$];
    logic [31:0] rdAddr;
    logic [31:0] wrAddr;
    logic [31:0] wrData;
    logic        arHs;
    logic        rHs;
    logic        awHs;
    logic        wHs;
    logic        bHs;
    logic        rPending;
    logic        awGot;
    logic        wGot;
    int          arWait;
    int          rWait;
    int          awWait;
    int          wWait;
    int          bWait;

    // Handshakes seen at the rising edge are acted on at the next falling edge
    always @(posedge clk)
    begin
        arHs <= axiOut.arvalid && axiIn.arready;
        rHs  <= axiOut.rready && axiIn.rvalid;
        awHs <= axiOut.awvalid && axiIn.awready;
        wHs  <= axiOut.wvalid && axiIn.wready;
        bHs  <= axiOut.bready && axiIn.bvalid;
        if (axiOut.arvalid && axiIn.arready)
        begin
            rdAddr <= axiOut.araddr;
            readLog.push_back(axiOut.araddr);
        end
        if (axiOut.awvalid && axiIn.awready)
            wrAddr <= axiOut.awaddr;
        if (axiOut.wvalid && axiIn.wready)
            wrData <= axiOut.wdata;
        if (axiOut.bready && axiIn.bvalid)
        begin
            mem[wrAddr[12:2]] = wrData;
            writeLog.push_back('{addr: wrAddr, wdata: wrData, write: 1'b1});
        end
    end

    initial
    begin
        axiIn <= '0;
        forever
        begin
            @(negedge clk);
            if (!arstN)
            begin
                axiIn    <= '0;
                rPending <= 1'b0;
                awGot    <= 1'b0;
                wGot     <= 1'b0;
                arWait   <= $urandom_range(3, 0);
                awWait   <= $urandom_range(3, 0);
                wWait    <= $urandom_range(3, 0);
                bWait    <= $urandom_range(3, 0);
            end
            else
            begin
                if (arHs)
                begin
                    axiIn.arready <= 1'b0;
                    arWait        <= $urandom_range(3, 0);
                    rPending      <= 1'b1;
                    rWait         <= $urandom_range(3, 0);
                end
                else if (axiOut.arvalid && !axiIn.arready)
                begin
                    if (arWait == 0)
                        axiIn.arready <= 1'b1;
                    else
                        arWait <= arWait - 1;
                end
                if (rHs)
                begin
                    axiIn.rvalid <= 1'b0;
                    rPending     <= 1'b0;
                end
                else if (rPending && !axiIn.rvalid)
                begin
                    if (rWait == 0)
                    begin
                        axiIn.rvalid <= 1'b1;
                        axiIn.rdata  <= mem[rdAddr[12:2]];
                    end
                    else
                        rWait <= rWait - 1;
                end
                if (awHs)
                begin
                    axiIn.awready <= 1'b0;
                    awWait        <= $urandom_range(3, 0);
                    awGot         <= 1'b1;
                end
                else if (axiOut.awvalid && !axiIn.awready && !awGot)
                begin
                    if (awWait == 0)
                        axiIn.awready <= 1'b1;
                    else
                        awWait <= awWait - 1;
                end
                if (wHs)
                begin
                    axiIn.wready <= 1'b0;
                    wWait        <= $urandom_range(3, 0);
                    wGot         <= 1'b1;
                end
                else if (axiOut.wvalid && !axiIn.wready && !wGot)
                begin
                    if (wWait == 0)
                        axiIn.wready <= 1'b1;
                    else
                        wWait <= wWait - 1;
                end
                // Write response once both address and data are in
                if (bHs)
                begin
                    axiIn.bvalid <= 1'b0;
                    awGot        <= 1'b0;
                    wGot         <= 1'b0;
                    bWait        <= $urandom_range(3, 0);
                end
                else if (awGot && wGot && !axiIn.bvalid)
                begin
                    if (bWait == 0)
                        axiIn.bvalid <= 1'b1;
                    else
                        bWait <= bWait - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/mipsTb.sv */
`default_nettype none

module mipsTb
    import mipsPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] dataBase = 32'h0000_1000;
    localparam int subIdx = 45;

    logic        clk;
    logic        arstN;
    axiMstT      axiOut;
    axiSlvT      axiIn;
    logic [31:0] prog [64];
    logic [31:0] dataWin [16];
    logic [31:0] expFetch [$];
    memReqT      expStore [$];
    logic [31:0] actFetch [$];
    int          modelSteps;
    int          modelLoads;
    int          errors;
    int          testsRun;
    int          testsFailed;
    bit          modelDone = 1'b0;
    bit          resetBad = 1'b0;
    bit          strbBad = 1'b0;

    mipsTop u_mipsTop (.clk, .arstN, .axiIn, .axiOut);

    axiMemSlave u_axiMemSlave (.clk, .arstN, .axiOut, .axiIn);

    initial
        clk = 1'b0;

    always #5 clk = ~clk;

    always @(negedge clk)
    begin
        if (!arstN && (axiOut.awvalid || axiOut.wvalid || axiOut.arvalid
                       || axiOut.rready || axiOut.bready))
            resetBad = 1'b1;
    end

    // Store beats always carry all four byte lanes
    always @(posedge clk)
    begin
        if (axiOut.wvalid && axiIn.wready && (axiOut.wstrb !== 4'hf))
            strbBad = 1'b1;
    end

    function automatic logic [31:0] fillWord(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] fn);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // r1 holds the data base and r2 the subroutine address
    function automatic logic [4:0] pickDst();
        logic [4:0] r;
        r = 5'($urandom_range(31, 0));
        if (r == 5'd1 || r == 5'd2)
            r = 5'd0;
        return r;
    endfunction

    task automatic buildProgram();
        int          k;
        int          hop;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] off;
        prog = '{default: '0};
        prog[0] = encI(opAddiu, 5'd0, 5'd1, dataBase[15:0]);
        prog[1] = encI(opAddiu, 5'd0, 5'd2, 16'(subIdx * 4));
        for (int i = 2; i < 42; i++)
        begin
            k   = $urandom_range(11, 0);
            rs  = 5'($urandom_range(31, 0));
            rt  = 5'($urandom_range(31, 0));
            off = {10'd0, 4'($urandom_range(15, 0)), 2'b00};
            case (k)
                0: prog[i] = encR(rs, rt, pickDst(), fnAddu);
                1: prog[i] = encR(rs, rt, pickDst(), fnSubu);
                2: prog[i] = encR(rs, rt, pickDst(), fnAnd);
                3: prog[i] = encR(rs, rt, pickDst(), fnOr);
                4: prog[i] = encR(rs, rt, pickDst(), fnSlt);
                5, 6: prog[i] = encI(opAddiu, rs, pickDst(), 16'($urandom));
                7: prog[i] = encI(opLui, 5'd0, pickDst(), 16'($urandom));
                8: prog[i] = encI(opLw, 5'd1, pickDst(), off);
                9: prog[i] = encI(opSw, 5'd1, rt, off);
                10:
                begin
                    // Small register pool so equal operands show up often
                    hop = $urandom_range(3, 0);
                    if (hop > 41 - i)
                        hop = 41 - i;
                    rs = 5'($urandom_range(5, 0));
                    rt = 5'($urandom_range(5, 0));
                    prog[i] = encI(($urandom_range(1, 0) == 0) ? opBeq : opBne,
                                   rs, rt, 16'(hop));
                end
                default: prog[i] = encR(5'd2, 5'd0, 5'd31, fnJalr);
            endcase
        end
        prog[42] = {opJal, 26'(subIdx)};
        prog[43] = encI(opSw, 5'd1, 5'd31, 16'd60);
        prog[44] = {opJ, 26'd44};
        prog[45] = encI(opAddiu, 5'd5, 5'd5, 16'd1);
        prog[46] = encI(opSw, 5'd1, 5'd5, 16'd56);
        prog[47] = encR(5'd31, 5'd0, 5'd0, fnJr);
    endtask

    // ISA reference model stepping one instruction at a time without a delay slot
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] nextPc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        instrT       iw;
        regs = '{default: '0};
        pc = resetPc;
        modelSteps = 0;
        modelLoads = 0;
        while (!modelDone && modelSteps < 1000)
        begin
            iw     = prog[pc[7:2]];
            a      = regs[iw.r.rs];
            b      = regs[iw.r.rt];
            sext   = {{16{iw.i.imm[15]}}, iw.i.imm};
            addr   = a + sext;
            pc4    = pc + 32'd4;
            nextPc = pc4;
            expFetch.push_back(pc);
            modelSteps++;
            case (iw.r.op)
                opRType:
                    case (iw.r.funct)
                        fnAddu: regs[iw.r.rd] = a + b;
                        fnSubu: regs[iw.r.rd] = a - b;
                        fnAnd:  regs[iw.r.rd] = a & b;
                        fnOr:   regs[iw.r.rd] = a | b;
                        fnSlt:  regs[iw.r.rd] = {31'd0, $signed(a) < $signed(b)};
                        fnJr:   nextPc = a;
                        fnJalr:
                        begin
                            regs[iw.r.rd] = pc4;
                            nextPc = a;
                        end
                        default: ;
                    endcase
                opAddiu: regs[iw.r.rt] = addr;
                opLui:   regs[iw.r.rt] = {iw.i.imm, 16'h0000};
                opLw:
                begin
                    regs[iw.r.rt] = dataWin[addr[5:2]];
                    modelLoads++;
                end
                opSw:
                begin
                    dataWin[addr[5:2]] = b;
                    expStore.push_back('{addr: addr, wdata: b, write: 1'b1});
                end
                opBeq: if (a == b) nextPc = pc4 + {sext[29:0], 2'b00};
                opBne: if (a != b) nextPc = pc4 + {sext[29:0], 2'b00};
                opJ:   nextPc = {pc4[31:28], iw.i[25:0], 2'b00};
                opJal:
                begin
                    regs[31] = pc4;
                    nextPc = {pc4[31:28], iw.i[25:0], 2'b00};
                end
                default: ;
            endcase
            regs[0] = '0;
            // The core fetches the self loop once more before the run ends
            if (nextPc == pc)
            begin
                expFetch.push_back(pc);
                modelDone = 1'b1;
            end
            pc = nextPc;
        end
    endtask

    function automatic int countFetches();
        int n;
        n = 0;
        for (int i = 0; i < u_axiMemSlave.readLog.size(); i++)
            if (u_axiMemSlave.readLog[i] < dataBase)
                n++;
        return n;
    endfunction

    task automatic checkFetch(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkStore(input string name, input memReqT expected, input memReqT actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        if (errors > errBefore)
        begin
            testsFailed++;
            $display("Test %-20s mismatch", name);
        end
        else
            $display("Test %-20s ok", name);
    endtask

    initial
    begin
        wait (modelDone);
        #(modelSteps * 40 * 10 + 80);
        $display("Watchdog: the core stopped making progress");
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        int errBefore;
        int actTotal;
        int nStores;
        void'($urandom(13738));
        arstN = 1'b0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        buildProgram();
        for (int i = 0; i < 2048; i++)
            u_axiMemSlave.mem[i] = fillWord(32'(i * 4));
        for (int i = 0; i < 64; i++)
            u_axiMemSlave.mem[i] = prog[i];
        for (int i = 0; i < 16; i++)
            dataWin[i] = fillWord(dataBase + 32'(i * 4));
        runModel();

        repeat (8) @(negedge clk);
        arstN = 1'b1;

        while (countFetches() < expFetch.size())
            @(negedge clk);
        actTotal = u_axiMemSlave.readLog.size() + u_axiMemSlave.writeLog.size();
        for (int i = 0; i < u_axiMemSlave.readLog.size(); i++)
            if (u_axiMemSlave.readLog[i] < dataBase)
                actFetch.push_back(u_axiMemSlave.readLog[i]);

        errBefore = errors;
        if (resetBad)
        begin
            $display("Error: an AXI valid or ready output was high during reset");
            errors++;
        end
        checkFetch("reset", resetPc, u_axiMemSlave.readLog[0]);
        reportTest("reset", errBefore);

        errBefore = errors;
        for (int i = 0; i < expFetch.size(); i++)
            checkFetch("fetch sequence", expFetch[i], actFetch[i]);
        reportTest("fetch sequence", errBefore);

        errBefore = errors;
        if (strbBad)
        begin
            $display("Error: a write beat did not enable all four byte lanes");
            errors++;
        end
        nStores = u_axiMemSlave.writeLog.size();
        if (nStores != expStore.size())
        begin
            $display("Error: the core made %0d stores where %0d were due",
                     nStores, expStore.size());
            errors++;
        end
        for (int i = 0; i < nStores && i < expStore.size(); i++)
            checkStore("store sequence", expStore[i], u_axiMemSlave.writeLog[i]);
        reportTest("store sequence", errBefore);

        errBefore = errors;
        checkCount("transaction count", expFetch.size() + modelLoads + expStore.size(),
                   actTotal);
        reportTest("transaction count", errBefore);

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mipsTop.f */
design/mipsPkg.sv
design/controlUnit.sv
design/regFile.sv
design/coreSequencer.sv
design/memArbiter.sv
design/mipsTop.sv
tests/axiMemSlave.sv
tests/mipsTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = mipsTb
FILELIST  = mipsTop.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
